/* rv_core.f */
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_bus.sv
hdl/rv_control.sv
hdl/rv_core.sv
tb/tb_mem.sv
tb/tb_core.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 -f rv_core.f --top-module tb_core -o sim_tb_core \
	&& ./obj_dir/sim_tb_core | tee sim.log \
	|| { echo "build or run error"; exit 1; }
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

/* tb/tb_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_core;
	localparam logic [31:0] reset_vector = 32'h0000_0200;
	localparam logic [31:0] res_base = 32'h0000_2000; // held in x31
	localparam logic [31:0] known_word = 32'h8f7a_45e1; // at res_base - 0x100

	logic clk;
	logic rstn;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic rvalid;
	logic rready;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;

	integer seed;
	int errors;
	int checks;
	int cur;
	int t;
	int n;
	logic hung;
	logic aw_seen;
	logic w_seen;
	logic [31:0] mask;
	logic [31:0] pc;
	logic [11:0] roff;
	logic [31:0] xr [32];
	string tname [$];
	int terr [$];
	logic [31:0] ra_q [$];
	int rt_q [$];
	logic [31:0] wa_q [$];
	logic [31:0] wd_q [$];
	logic [3:0] ws_q [$];
	int wt_q [$];

	string alu_names [10] = '{"add", "sub", "xor", "or", "and", "sll", "srl", "sra", "slt",
		"sltu"};
	logic [2:0] alu_f3 [10] = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5, 3'd2, 3'd3};
	logic alu_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	string br_names [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
	logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	rv_core #(
		.reset_vector(reset_vector)
	) UUT (
		.clk(clk),
		.rstn(rstn),
		.m_axi_araddr(araddr),
		.m_axi_arvalid(arvalid),
		.m_axi_arready(arready),
		.m_axi_rdata(rdata),
		.m_axi_rvalid(rvalid),
		.m_axi_rready(rready),
		.m_axi_awaddr(awaddr),
		.m_axi_awvalid(awvalid),
		.m_axi_awready(awready),
		.m_axi_wdata(wdata),
		.m_axi_wstrb(wstrb),
		.m_axi_wvalid(wvalid),
		.m_axi_wready(wready),
		.m_axi_bvalid(bvalid),
		.m_axi_bready(bready)
	);

	tb_mem u_mem (
		.clk(clk),
		.rstn(rstn),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rready(rready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	// riscv arithmetic rules with the shift amount from b[4:0]
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return (a >> b[4:0]) | (alt && a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
			3'd0: return x == y;
			3'd1: return x != y;
			3'd4: return $signed(x) < $signed(y);
			3'd5: return $signed(x) >= $signed(y);
			3'd6: return x < y;
			default: return x >= y;
		endcase
	endfunction

	task automatic check(input int ti, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			terr[ti]++;
			$display("ERR %s %s expected %h actual %h", tname[ti], what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		tname.push_back(name);
		terr.push_back(0);
		cur = tname.size() - 1;
	endtask

	task automatic emit(input logic [31:0] w);
		u_mem.mem[pc[13:2]] = w;
		ra_q.push_back(pc);
		rt_q.push_back(cur);
		pc = pc + 32'd4;
	endtask

	// placed in memory but never fetched
	task automatic place(input logic [31:0] w);
		u_mem.mem[pc[13:2]] = w;
		pc = pc + 32'd4;
	endtask

	task automatic expect_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
		wa_q.push_back(a);
		wd_q.push_back(d);
		ws_q.push_back(s);
		wt_q.push_back(cur);
	endtask

	task automatic set_reg(input logic [4:0] r, input logic [31:0] val);
		logic [31:0] hi;
		hi = (val + 32'h800) >> 12;
		emit({hi[19:0], r, 7'h37});
		emit({val[11:0], r, 3'b000, r, 7'h13});
		xr[r] = val;
	endtask

	task automatic store_reg(input logic [4:0] r);
		emit(enc_s(roff, r, 5'd31, 3'b010));
		expect_write(res_base + {20'd0, roff}, xr[r], 4'hf);
		roff = roff + 12'd4;
	endtask

	task automatic alu_tests();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [11:0] field;
		for (int i = 0; i < 10; i++) begin
			start_test({alu_names[i], "_r"});
			a = $random(seed);
			b = $random(seed);
			set_reg(5'd1, a);
			set_reg(5'd2, b);
			emit({alu_alt[i] ? 7'h20 : 7'h00, 5'd2, 5'd1, alu_f3[i], 5'd3, 7'h33});
			xr[3] = alu_ref(alu_f3[i], alu_alt[i], a, b);
			store_reg(5'd3);
			if (i != 1) begin
				start_test({alu_names[i], "_i"});
				a = $random(seed);
				r = $random(seed);
				if (alu_f3[i] == 3'd1 || alu_f3[i] == 3'd5) begin
					b = {27'd0, r[4:0]};
					field = {alu_alt[i] ? 7'h20 : 7'h00, r[4:0]};
				end else begin
					b = {{20{r[11]}}, r[11:0]};
					field = r[11:0];
				end
				set_reg(5'd1, a);
				emit({field, 5'd1, alu_f3[i], 5'd3, 7'h13});
				xr[3] = alu_ref(alu_f3[i], alu_alt[i], a, b);
				store_reg(5'd3);
			end
		end
	endtask

	task automatic mem_tests();
		logic [31:0] v;
		logic [31:0] wa;
		logic [7:0] by;
		logic [15:0] hw;
		logic [2:0] f3;
		start_test("sb");
		v = $random(seed);
		set_reg(5'd1, v);
		wa = res_base + {20'd0, roff};
		for (int k = 0; k < 4; k++) begin
			emit(enc_s(roff + 12'(k), 5'd1, 5'd31, 3'b000));
			expect_write(wa, {24'd0, v[7:0]} << (8 * (3 - k)), 4'b1000 >> k);
		end
		roff = roff + 12'd4;
		start_test("sh");
		wa = res_base + {20'd0, roff};
		emit(enc_s(roff, 5'd1, 5'd31, 3'b001));
		expect_write(wa, {v[15:0], 16'd0}, 4'b1100);
		emit(enc_s(roff + 12'd2, 5'd1, 5'd31, 3'b001));
		expect_write(wa, {16'd0, v[15:0]}, 4'b0011);
		roff = roff + 12'd4;
		for (int m = 0; m < 5; m++) begin
			case (m)
				0: start_test("lb");
				1: start_test("lbu");
				2: start_test("lh");
				3: start_test("lhu");
				default: start_test("lw");
			endcase
			f3 = m == 0 ? 3'd0 : m == 1 ? 3'd4 : m == 2 ? 3'd1 : m == 3 ? 3'd5 : 3'd2;
			for (int k = 0; k < 4; k++) begin
				if (m < 2 || (m < 4 && k[0] == 1'b0) || k == 0) begin
					emit({12'hf00 + 12'(k), 5'd31, f3, 5'd4, 7'h03});
					ra_q.push_back(res_base - 32'h100);
					rt_q.push_back(cur);
					by = known_word[8 * (3 - k) +: 8];
					hw = k == 0 ? known_word[31:16] : known_word[15:0];
					case (m)
						0: xr[4] = {{24{by[7]}}, by};
						1: xr[4] = {24'd0, by};
						2: xr[4] = {{16{hw[15]}}, hw};
						3: xr[4] = {16'd0, hw};
						default: xr[4] = known_word;
					endcase
					store_reg(5'd4);
				end
			end
		end
	endtask

	task automatic flow_tests();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] pc0;
		logic [31:0] skip;
		skip = {12'd1, 5'd5, 3'b000, 5'd5, 7'h13}; // addi x5, x5, 1
		for (int i = 0; i < 6; i++) begin
			start_test(br_names[i]);
			for (int p = 0; p < 3; p++) begin
				a = $random(seed);
				b = $random(seed);
				x = p == 2 ? b : a;
				y = p == 1 ? b : a;
				set_reg(5'd1, x);
				set_reg(5'd2, y);
				emit(enc_b(13'd8, 5'd2, 5'd1, br_f3[i]));
				if (br_ref(br_f3[i], x, y)) begin
					place(skip);
				end else begin
					emit(skip);
					xr[5] = xr[5] + 32'd1;
				end
				store_reg(5'd5);
			end
		end
		start_test("jal");
		xr[6] = pc + 32'd4;
		emit(enc_j(21'd8, 5'd6));
		place(skip);
		store_reg(5'd6);
		start_test("jalr");
		pc0 = pc;
		set_reg(5'd7, pc0 + 32'd16);
		emit({12'd0, 5'd7, 3'b000, 5'd6, 7'h67});
		xr[6] = pc0 + 32'd12;
		place(skip);
		store_reg(5'd6);
		start_test("lui");
		a = $random(seed);
		emit({a[19:0], 5'd8, 7'h37});
		xr[8] = {a[19:0], 12'd0};
		store_reg(5'd8);
		start_test("auipc");
		a = $random(seed);
		xr[8] = pc + {a[19:0], 12'd0};
		emit({a[19:0], 5'd8, 7'h17});
		store_reg(5'd8);
		start_test("undef");
		set_reg(5'd9, $random(seed));
		emit({20'habcde, 5'd9, 7'h7f});
		store_reg(5'd9);
	endtask

	task automatic build_program();
		for (int i = 0; i < 4096; i++)
			u_mem.mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
		u_mem.mem[(res_base - 32'h100) >> 2] = known_word;
		for (int i = 0; i < 32; i++)
			xr[i] = '0;
		pc = reset_vector;
		roff = '0;
		start_test("reset");
		set_reg(5'd31, res_base);
		alu_tests();
		mem_tests();
		flow_tests();
		place(enc_j(21'd0, 5'd0)); // park in a loop
	endtask

	// fetch and load addresses in program order
	always @(posedge clk) begin
		if (rstn && arvalid && arready && ra_q.size() > 0) begin
			check(rt_q[0], "araddr", ra_q[0], araddr);
			void'(ra_q.pop_front());
			void'(rt_q.pop_front());
		end
	end

	always @(posedge clk) begin
		if (rstn) begin
			if ((awvalid && awready) || (wvalid && wready)) begin
				assert (wa_q.size() != 0) else begin
					errors++;
					$display("unexpected write at address %h", awaddr);
				end
			end
			if (awvalid && awready && wa_q.size() > 0) begin
				aw_seen = 1'b1;
				check(wt_q[0], "awaddr", wa_q[0], awaddr);
			end
			if (wvalid && wready && wa_q.size() > 0) begin
				w_seen = 1'b1;
				check(wt_q[0], "wstrb", {28'd0, ws_q[0]}, {28'd0, wstrb});
				mask = {{8{ws_q[0][3]}}, {8{ws_q[0][2]}}, {8{ws_q[0][1]}}, {8{ws_q[0][0]}}};
				check(wt_q[0], "wdata", wd_q[0] & mask, wdata & mask);
			end
			if (aw_seen && w_seen) begin
				aw_seen = 1'b0;
				w_seen = 1'b0;
				t = wt_q[0];
				void'(wa_q.pop_front());
				void'(wd_q.pop_front());
				void'(ws_q.pop_front());
				void'(wt_q.pop_front());
				if (wt_q.size() == 0 || wt_q[0] != t)
					$display("%s done, %0d errors", tname[t], terr[t]);
			end
		end
	end

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		seed = 32'hcd17_adc7;
		errors = 0;
		checks = 0;
		hung = 1'b0;
		aw_seen = 1'b0;
		w_seen = 1'b0;
		build_program();
		repeat (10) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		check(0, "valid/ready after reset", 32'd0,
			{27'd0, arvalid, rready, awvalid, wvalid, bready});
		n = 0;
		while (!arvalid && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!arvalid) begin
			hung = 1'b1;
			$display("no fetch started after reset");
		end else begin
			check(0, "first araddr", reset_vector, araddr);
		end
		$display("%s done, %0d errors", tname[0], terr[0]);
		n = 0;
		while (!hung && (wa_q.size() != 0 || ra_q.size() != 0) && n < 200000) begin
			@(negedge clk);
			n++;
		end
		if (!hung && (wa_q.size() != 0 || ra_q.size() != 0)) begin
			hung = 1'b1;
			$display("timeout with %0d reads and %0d writes still expected",
				ra_q.size(), wa_q.size());
		end
		$display("tests %0d, checks %0d, errors %0d", tname.size(), checks, errors);
		if (hung || errors != 0)
			$display("test failed");
		else
			$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tb_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem (
	input  logic        clk,
	input  logic        rstn,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic        rvalid,
	input  logic        rready,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic        bvalid,
	input  logic        bready
);
	logic [31:0] mem [4096];
	integer seed;
	logic [11:0] raddr;
	logic [11:0] waddr;
	logic [31:0] wdata_q;
	logic [3:0] wstrb_q;
	logic rd_busy;
	logic aw_got;
	logic w_got;

	// ready or valid goes out about three cycles in four
	function automatic logic go();
		logic [31:0] r;
		r = $random(seed);
		return r[1:0] != 2'b00;
	endfunction

	initial begin
		seed = 32'hcd17_adc7;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
	end

	always @(posedge clk) begin
		if (!rstn) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			rd_busy <= 1'b0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				raddr <= araddr[13:2]; // word index
				rd_busy <= 1'b1;
				arready <= 1'b0;
			end else if (!rd_busy) begin
				arready <= go();
			end
			if (rd_busy && !rvalid && go()) begin
				rvalid <= 1'b1;
				rdata <= mem[raddr];
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				rd_busy <= 1'b0;
			end
			if (awvalid && awready) begin
				waddr <= awaddr[13:2];
				aw_got <= 1'b1;
				awready <= 1'b0;
			end else if (!aw_got && !bvalid) begin
				awready <= go();
			end
			if (wvalid && wready) begin
				wdata_q <= wdata;
				wstrb_q <= wstrb;
				w_got <= 1'b1;
				wready <= 1'b0;
			end else if (!w_got && !bvalid) begin
				wready <= go();
			end
			if (aw_got && w_got && !bvalid && go()) begin
				for (int i = 0; i < 4; i++)
					if (wstrb_q[i])
						mem[waddr][i*8 +: 8] <= wdata_q[i*8 +: 8];
				bvalid <= 1'b1;
				aw_got <= 1'b0;
				w_got <= 1'b0;
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
	parameter rv_pkg::word_t reset_vector = '0
) (
	input  logic          clk,
	input  logic          rstn,
	output rv_pkg::word_t m_axi_araddr,
	output logic          m_axi_arvalid,
	input  logic          m_axi_arready,
	input  rv_pkg::word_t m_axi_rdata,
	input  logic          m_axi_rvalid,
	output logic          m_axi_rready,
	output rv_pkg::word_t m_axi_awaddr,
	output logic          m_axi_awvalid,
	input  logic          m_axi_awready,
	output rv_pkg::word_t m_axi_wdata,
	output logic [3:0]    m_axi_wstrb,
	output logic          m_axi_wvalid,
	input  logic          m_axi_wready,
	input  logic          m_axi_bvalid,
	output logic          m_axi_bready
);
	logic fetch_req;
	logic load_req;
	logic store_req;
	logic done;
	logic load_unsigned;
	logic mem_unsigned;
	logic wb_en;
	rv_pkg::word_t addr;
	rv_pkg::word_t store_data;
	rv_pkg::word_t rdata_ext;
	rv_pkg::word_t instr_word;
	rv_pkg::word_t imm;
	rv_pkg::word_t rs1_val;
	rv_pkg::word_t rs2_val;
	rv_pkg::word_t op_a;
	rv_pkg::word_t op_b;
	rv_pkg::word_t alu_result;
	rv_pkg::word_t wb_data;
	rv_pkg::reg_idx_t rs1;
	rv_pkg::reg_idx_t rs2;
	rv_pkg::reg_idx_t rd;
	rv_pkg::reg_idx_t wb_idx;
	rv_pkg::size_e size;
	rv_pkg::size_e mem_size;
	rv_pkg::instr_e cls;
	rv_pkg::alu_op_e alu_op;

	rv_control #(
		.reset_vector(reset_vector)
	) u_control (
		.clk(clk),
		.rstn(rstn),
		.done(done),
		.rdata_ext(rdata_ext),
		.cls(cls),
		.imm(imm),
		.rd(rd),
		.mem_size(mem_size),
		.mem_unsigned(mem_unsigned),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.alu_result(alu_result),
		.fetch_req(fetch_req),
		.load_req(load_req),
		.store_req(store_req),
		.addr(addr),
		.size(size),
		.load_unsigned(load_unsigned),
		.store_data(store_data),
		.instr_word(instr_word),
		.op_a(op_a),
		.op_b(op_b),
		.wb_en(wb_en),
		.wb_idx(wb_idx),
		.wb_data(wb_data)
	);

	rv_decoder u_decoder (
		.clk(clk),
		.rstn(rstn),
		.instr_word(instr_word),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.imm(imm),
		.cls(cls),
		.alu_op(alu_op),
		.mem_size(mem_size),
		.mem_unsigned(mem_unsigned)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.rstn(rstn),
		.rs1(rs1),
		.rs2(rs2),
		.wb_en(wb_en),
		.wb_idx(wb_idx),
		.wb_data(wb_data),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val)
	);

	rv_alu u_alu (
		.clk(clk),
		.rstn(rstn),
		.op_a(op_a),
		.op_b(op_b),
		.alu_op(alu_op),
		.alu_result(alu_result)
	);

	rv_bus u_bus (
		.clk(clk),
		.rstn(rstn),
		.fetch_req(fetch_req),
		.load_req(load_req),
		.store_req(store_req),
		.addr(addr),
		.size(size),
		.load_unsigned(load_unsigned),
		.store_data(store_data),
		.done(done),
		.rdata_ext(rdata_ext),
		.m_axi_araddr(m_axi_araddr),
		.m_axi_arvalid(m_axi_arvalid),
		.m_axi_arready(m_axi_arready),
		.m_axi_rdata(m_axi_rdata),
		.m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready),
		.m_axi_awaddr(m_axi_awaddr),
		.m_axi_awvalid(m_axi_awvalid),
		.m_axi_awready(m_axi_awready),
		.m_axi_wdata(m_axi_wdata),
		.m_axi_wstrb(m_axi_wstrb),
		.m_axi_wvalid(m_axi_wvalid),
		.m_axi_wready(m_axi_wready),
		.m_axi_bvalid(m_axi_bvalid),
		.m_axi_bready(m_axi_bready)
	);

endmodule

`default_nettype wire

/* hdl/rv_control.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_control #(
	parameter rv_pkg::word_t reset_vector = '0
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic             done,
	input  rv_pkg::word_t    rdata_ext,
	input  rv_pkg::instr_e   cls,
	input  rv_pkg::word_t    imm,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::size_e    mem_size,
	input  logic             mem_unsigned,
	input  rv_pkg::word_t    rs1_val,
	input  rv_pkg::word_t    rs2_val,
	input  rv_pkg::word_t    alu_result,
	output logic             fetch_req,
	output logic             load_req,
	output logic             store_req,
	output rv_pkg::word_t    addr,
	output rv_pkg::size_e    size,
	output logic             load_unsigned,
	output rv_pkg::word_t    store_data,
	output rv_pkg::word_t    instr_word,
	output rv_pkg::word_t    op_a,
	output rv_pkg::word_t    op_b,
	output logic             wb_en,
	output rv_pkg::reg_idx_t wb_idx,
	output rv_pkg::word_t    wb_data
);
	typedef enum logic [2:0] {st_fetch, st_decode, st_exec, st_mem, st_write} state_e;

	state_e state;
	rv_pkg::word_t pc;
	rv_pkg::word_t pc_plus4;
	rv_pkg::word_t pc_imm;
	rv_pkg::word_t mem_addr;
	rv_pkg::word_t next_pc;
	logic pending;
	logic is_mem;

	assign pc_plus4 = pc + 32'd4;
	assign pc_imm = pc + imm;
	assign mem_addr = rs1_val + imm;
	assign is_mem = cls == rv_pkg::cls_load || cls == rv_pkg::cls_store;

	// one request per state visit
	assign fetch_req = state == st_fetch && !pending;
	assign load_req = state == st_mem && cls == rv_pkg::cls_load && !pending;
	assign store_req = state == st_mem && cls == rv_pkg::cls_store && !pending;
	assign addr = state == st_fetch ? pc : mem_addr;
	assign size = mem_size;
	assign load_unsigned = mem_unsigned;
	assign store_data = rs2_val;

	assign op_a = rs1_val;
	assign op_b = instr_word[5] ? rs2_val : imm; // opcode bit 5 marks reg and branch forms

	assign wb_en = state == st_write && rd != '0;
	assign wb_idx = rd;

	always_comb begin
		case (cls)
			rv_pkg::cls_lui: wb_data = imm;
			rv_pkg::cls_auipc: wb_data = pc_imm;
			rv_pkg::cls_load: wb_data = rdata_ext;
			rv_pkg::cls_jal, rv_pkg::cls_jalr: wb_data = pc_plus4;
			default: wb_data = alu_result;
		endcase
	end

	always_comb begin
		case (cls)
			rv_pkg::cls_jal: next_pc = pc_imm;
			rv_pkg::cls_jalr: next_pc = {mem_addr[31:1], 1'b0};
			rv_pkg::cls_branch: next_pc = alu_result != '0 ? pc_imm : pc_plus4;
			default: next_pc = pc_plus4; // undefined words fall through here too
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_fetch;
			pc <= reset_vector;
			pending <= 1'b0;
		end else begin
			if (pending)
				pending <= !done;
			else
				pending <= fetch_req || load_req || store_req;
			case (state)
				st_fetch: if (done) state <= st_decode;
				st_decode: state <= st_exec;
				st_exec: state <= st_mem;
				st_mem: if (!is_mem || done) state <= st_write;
				st_write: begin
					pc <= next_pc;
					state <= st_fetch;
				end
				default: state <= st_fetch;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch && done)
			instr_word <= rdata_ext;
	end

endmodule

`default_nettype wire

/* hdl/rv_bus.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_bus (
	input  logic           clk,
	input  logic           rstn,
	input  logic           fetch_req,
	input  logic           load_req,
	input  logic           store_req,
	input  rv_pkg::word_t  addr,
	input  rv_pkg::size_e  size,
	input  logic           load_unsigned,
	input  rv_pkg::word_t  store_data,
	output logic           done,
	output rv_pkg::word_t  rdata_ext,
	output rv_pkg::word_t  m_axi_araddr,
	output logic           m_axi_arvalid,
	input  logic           m_axi_arready,
	input  rv_pkg::word_t  m_axi_rdata,
	input  logic           m_axi_rvalid,
	output logic           m_axi_rready,
	output rv_pkg::word_t  m_axi_awaddr,
	output logic           m_axi_awvalid,
	input  logic           m_axi_awready,
	output rv_pkg::word_t  m_axi_wdata,
	output logic [3:0]     m_axi_wstrb,
	output logic           m_axi_wvalid,
	input  logic           m_axi_wready,
	input  logic           m_axi_bvalid,
	output logic           m_axi_bready
);
	typedef enum logic [2:0] {st_idle, st_ar, st_r, st_w, st_b} state_e;

	state_e state;
	rv_pkg::word_t word_addr;
	logic [1:0] off;
	rv_pkg::size_e sz;
	logic uns;
	rv_pkg::word_t lane_data;
	logic [3:0] lane_strb;
	logic [7:0] rd_byte;
	logic [15:0] rd_half;
	rv_pkg::word_t rd_ext;

	assign m_axi_araddr = word_addr;
	assign m_axi_awaddr = word_addr;

	// offset 0 lands in bits 31:24
	always_comb begin
		case (size)
			rv_pkg::size_b: begin
				lane_data = {24'd0, store_data[7:0]} << {~addr[1:0], 3'b000};
				lane_strb = 4'b1000 >> addr[1:0];
			end
			rv_pkg::size_h: begin
				lane_data = addr[1] ? {16'd0, store_data[15:0]} : {store_data[15:0], 16'd0};
				lane_strb = addr[1] ? 4'b0011 : 4'b1100;
			end
			default: begin
				lane_data = store_data;
				lane_strb = 4'b1111;
			end
		endcase
	end

	assign rd_byte = m_axi_rdata[{~off, 3'b000} +: 8];
	assign rd_half = off[1] ? m_axi_rdata[15:0] : m_axi_rdata[31:16];

	always_comb begin
		case (sz)
			rv_pkg::size_b: rd_ext = uns ? {24'd0, rd_byte} : {{24{rd_byte[7]}}, rd_byte};
			rv_pkg::size_h: rd_ext = uns ? {16'd0, rd_half} : {{16{rd_half[15]}}, rd_half};
			default: rd_ext = m_axi_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_idle;
			m_axi_arvalid <= 1'b0;
			m_axi_rready <= 1'b0;
			m_axi_awvalid <= 1'b0;
			m_axi_wvalid <= 1'b0;
			m_axi_bready <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: begin
					if (fetch_req || load_req) begin
						m_axi_arvalid <= 1'b1;
						state <= st_ar;
					end else if (store_req) begin
						m_axi_awvalid <= 1'b1;
						m_axi_wvalid <= 1'b1;
						state <= st_w;
					end
				end
				st_ar: begin
					if (m_axi_arready) begin
						m_axi_arvalid <= 1'b0;
						m_axi_rready <= 1'b1;
						state <= st_r;
					end
				end
				st_r: begin
					if (m_axi_rvalid) begin
						m_axi_rready <= 1'b0;
						done <= 1'b1;
						state <= st_idle;
					end
				end
				st_w: begin
					if (m_axi_awready)
						m_axi_awvalid <= 1'b0;
					if (m_axi_wready)
						m_axi_wvalid <= 1'b0;
					if ((!m_axi_awvalid || m_axi_awready) && (!m_axi_wvalid || m_axi_wready)) begin
						m_axi_bready <= 1'b1; // both channels taken
						state <= st_b;
					end
				end
				st_b: begin
					if (m_axi_bvalid) begin
						m_axi_bready <= 1'b0;
						done <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			word_addr <= {addr[31:2], 2'b00};
			off <= addr[1:0];
			sz <= fetch_req ? rv_pkg::size_w : size; // fetch is a plain word
			uns <= load_unsigned;
			m_axi_wdata <= lane_data;
			m_axi_wstrb <= lane_strb;
		end
		if (state == st_r && m_axi_rvalid)
			rdata_ext <= rd_ext;
	end

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
	input  logic            clk,
	input  logic            rstn,
	input  rv_pkg::word_t   op_a,
	input  rv_pkg::word_t   op_b,
	input  rv_pkg::alu_op_e alu_op,
	output rv_pkg::word_t   alu_result
);
	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;
	logic eq;

	assign shamt = op_b[4:0];
	assign lt_s = $signed(op_a) < $signed(op_b);
	assign lt_u = op_a < op_b;
	assign eq = op_a == op_b;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			alu_result <= '0;
		end else begin
			case (alu_op)
				rv_pkg::alu_add: alu_result <= op_a + op_b;
				rv_pkg::alu_sub: alu_result <= op_a - op_b;
				rv_pkg::alu_sll: alu_result <= op_a << shamt;
				rv_pkg::alu_srl: alu_result <= op_a >> shamt;
				rv_pkg::alu_sra: alu_result <= $signed(op_a) >>> shamt;
				rv_pkg::alu_xor: alu_result <= op_a ^ op_b;
				rv_pkg::alu_or: alu_result <= op_a | op_b;
				rv_pkg::alu_and: alu_result <= op_a & op_b;
				rv_pkg::alu_slt, rv_pkg::alu_lt: alu_result <= rv_pkg::word_t'(lt_s);
				rv_pkg::alu_sltu, rv_pkg::alu_ltu: alu_result <= rv_pkg::word_t'(lt_u);
				rv_pkg::alu_eq: alu_result <= rv_pkg::word_t'(eq);
				rv_pkg::alu_ne: alu_result <= rv_pkg::word_t'(!eq);
				rv_pkg::alu_ge: alu_result <= rv_pkg::word_t'(!lt_s);
				rv_pkg::alu_geu: alu_result <= rv_pkg::word_t'(!lt_u);
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
	input  logic             clk,
	input  logic             rstn,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	input  logic             wb_en,
	input  rv_pkg::reg_idx_t wb_idx,
	input  rv_pkg::word_t    wb_data,
	output rv_pkg::word_t    rs1_val,
	output rv_pkg::word_t    rs2_val
);
	rv_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_idx != '0) begin
			regs[wb_idx] <= wb_data; // x0 never written
		end
	end

	always_ff @(posedge clk) begin
		rs1_val <= regs[rs1];
		rs2_val <= regs[rs2];
	end

endmodule

`default_nettype wire

/* hdl/rv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
	input  logic             clk,
	input  logic             rstn,
	input  rv_pkg::word_t    instr_word,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::reg_idx_t rd,
	output rv_pkg::word_t    imm,
	output rv_pkg::instr_e   cls,
	output rv_pkg::alu_op_e  alu_op,
	output rv_pkg::size_e    mem_size,
	output logic             mem_unsigned
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic alt;
	logic arith_ok;
	logic has_rd;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_b;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm_j;
	rv_pkg::word_t imm_d;
	rv_pkg::instr_e cls_d;
	rv_pkg::alu_op_e alu_d;
	rv_pkg::size_e size_d;

	assign opcode = instr_word[6:0];
	assign funct3 = instr_word[14:12];
	assign funct7 = instr_word[31:25];
	assign alt = funct7 == 7'b0100000; // sub and sra
	assign rs1 = instr_word[19:15];
	assign rs2 = instr_word[24:20];

	assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
	assign imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
	assign imm_b = {{20{instr_word[31]}}, instr_word[7], instr_word[30:25],
		instr_word[11:8], 1'b0};
	assign imm_u = {instr_word[31:12], 12'd0};
	assign imm_j = {{12{instr_word[31]}}, instr_word[19:12], instr_word[20],
		instr_word[30:21], 1'b0};

	always_comb begin
		case (funct3)
			3'b001: arith_ok = funct7 == 7'd0;
			3'b101: arith_ok = funct7 == 7'd0 || alt;
			default: arith_ok = opcode == rv_pkg::op_imm || funct7 == 7'd0 ||
				(alt && funct3 == 3'b000);
		endcase
	end

	always_comb begin
		cls_d = rv_pkg::cls_none;
		alu_d = rv_pkg::alu_add;
		size_d = rv_pkg::size_e'(funct3[1:0]);
		imm_d = imm_i;
		has_rd = 1'b0;
		case (opcode)
			rv_pkg::op_lui: begin
				cls_d = rv_pkg::cls_lui;
				imm_d = imm_u;
				has_rd = 1'b1;
			end
			rv_pkg::op_auipc: begin
				cls_d = rv_pkg::cls_auipc;
				imm_d = imm_u;
				has_rd = 1'b1;
			end
			rv_pkg::op_jal: begin
				cls_d = rv_pkg::cls_jal;
				imm_d = imm_j;
				has_rd = 1'b1;
			end
			rv_pkg::op_jalr: begin
				cls_d = funct3 == 3'b000 ? rv_pkg::cls_jalr : rv_pkg::cls_none;
				has_rd = funct3 == 3'b000;
			end
			rv_pkg::op_branch: begin
				imm_d = imm_b;
				cls_d = rv_pkg::cls_branch;
				case (funct3)
					3'b000: alu_d = rv_pkg::alu_eq;
					3'b001: alu_d = rv_pkg::alu_ne;
					3'b100: alu_d = rv_pkg::alu_lt;
					3'b101: alu_d = rv_pkg::alu_ge;
					3'b110: alu_d = rv_pkg::alu_ltu;
					3'b111: alu_d = rv_pkg::alu_geu;
					default: cls_d = rv_pkg::cls_none;
				endcase
			end
			rv_pkg::op_load: begin
				if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
					cls_d = rv_pkg::cls_load;
					has_rd = 1'b1;
				end
			end
			rv_pkg::op_store: begin
				imm_d = imm_s;
				if (!funct3[2] && funct3[1:0] != 2'b11)
					cls_d = rv_pkg::cls_store;
			end
			rv_pkg::op_imm, rv_pkg::op_reg: begin
				if (arith_ok) begin
					cls_d = rv_pkg::cls_alu;
					has_rd = 1'b1;
				end
				case (funct3)
					3'b000: alu_d = (alt && opcode == rv_pkg::op_reg) ? rv_pkg::alu_sub
						: rv_pkg::alu_add;
					3'b001: alu_d = rv_pkg::alu_sll;
					3'b010: alu_d = rv_pkg::alu_slt;
					3'b011: alu_d = rv_pkg::alu_sltu;
					3'b100: alu_d = rv_pkg::alu_xor;
					3'b101: alu_d = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
					3'b110: alu_d = rv_pkg::alu_or;
					default: alu_d = rv_pkg::alu_and;
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cls <= rv_pkg::cls_none;
			rd <= '0;
		end else begin
			cls <= cls_d;
			rd <= has_rd ? instr_word[11:7] : '0; // no write for branch and store
		end
	end

	always_ff @(posedge clk) begin
		imm <= imm_d;
		alu_op <= alu_d;
		mem_size <= size_d;
		mem_unsigned <= funct3[2];
	end

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_eq,
		alu_ne,
		alu_lt,
		alu_ge,
		alu_ltu,
		alu_geu
	} alu_op_e;

	// same order as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		size_b,
		size_h,
		size_w
	} size_e;

	// nine classes need four bits
	typedef enum logic [3:0] {
		cls_none,
		cls_alu,
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store
	} instr_e;

endpackage

`default_nettype wire
